// File: Makefile
# Verilator build and run of the UART transmit testbench
TOP := tb_uart_tx
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_uart_tx.sv
// clock, reset, random batches, line decoder model and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx;

    localparam int wait_limit = 20000;
    localparam int resync_limit = 70000;

    logic                     clk;
    logic                     rst_n;
    uart_tx_pkg::client_wr_t  client0;
    uart_tx_pkg::client_wr_t  client1;
    logic [1:0]               req;
    uart_tx_pkg::prescale_t   prescaler;
    logic                     en;
    logic                     tx_en;
    uart_cfg_pkg::frame_cfg_t frame_cfg;
    logic [1:0]               grant;
    logic                     tx_empty;
    logic                     tx_full;
    uart_tx_pkg::level_t      tx_level;
    logic                     tx_done;
    logic                     tx;

    // words the FIFO accepted, oldest first
    uart_tx_pkg::word_t expected_q[$];
    int errors = 0;
    int checks = 0;
    int pushed_cnt = 0;
    int done_cnt = 0;
    int frames_seen = 0;

    uart_tx_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .client0   (client0),
        .client1   (client1),
        .req       (req),
        .prescaler (prescaler),
        .en        (en),
        .tx_en     (tx_en),
        .frame_cfg (frame_cfg),
        .grant     (grant),
        .tx_empty  (tx_empty),
        .tx_full   (tx_full),
        .tx_level  (tx_level),
        .tx_done   (tx_done),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input uart_tx_pkg::word_t got,
                              input uart_tx_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_grant(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input uart_tx_pkg::level_t got,
                               input uart_tx_pkg::level_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d, assertion failures %0d, frames %0d",
                 checks, errors, i_dut.i_assertions.fail_cnt, frames_seen);
    endtask

    task automatic abort(input string why);
        errors++;
        $display("%s", why);
        print_counts();
        $display("test failed");
        $finish;
    endtask

    // inputs change just after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // parity bit the line should carry for a masked word
    function automatic logic parity_of(input uart_tx_pkg::word_t w,
                                       input uart_cfg_pkg::frame_cfg_t c);
        int ones;
        ones = $countones(w);
        case (c.parity)
            // odd mode makes the total count of ones odd
            uart_cfg_pkg::par_odd:     return (ones % 2) == 0;
            uart_cfg_pkg::par_even:    return (ones % 2) == 1;
            uart_cfg_pkg::par_sticky1: return 1'b1;
            default:                   return 1'b0;
        endcase
    endfunction

    // mid-period samples counted in clocks with ticks enabled
    task automatic decode_frame();
        int period;
        int ds;
        int nbits;
        int cnt;
        int waited;
        int target;
        logic bits_q[$];
        uart_tx_pkg::word_t got;
        uart_tx_pkg::word_t exp;
        period = uart_tx_pkg::samples_per_bit * (int'(prescaler) + 1);
        ds = int'(frame_cfg.data_size);
        nbits = 2 + ds + (frame_cfg.parity != uart_cfg_pkg::par_none ? 1 : 0)
                + (frame_cfg.two_stop ? 1 : 0);
        cnt = (en && tx_en) ? 1 : 0;
        waited = 0;
        for (int k = 0; k < nbits; k++) begin
            target = k * period + period / 2;
            while (cnt < target) begin
                if (waited == wait_limit) begin
                    abort("timeout while decoding a frame on tx");
                end
                @(negedge clk);
                waited++;
                if (en && tx_en) begin
                    cnt++;
                end
            end
            bits_q.push_back(tx);
        end
        check_bit("tx start", bits_q[0], 1'b0);
        got = '0;
        for (int i = 0; i < ds; i++) begin
            got = got | (uart_tx_pkg::word_t'(bits_q[1 + i]) << i);
        end
        if (expected_q.size() == 0) begin
            errors++;
            $display("a frame was decoded while no word was queued");
            return;
        end
        exp = expected_q.pop_front() & uart_tx_pkg::word_t'((1 << ds) - 1);
        check_word("tx data", got, exp);
        if (frame_cfg.parity != uart_cfg_pkg::par_none) begin
            check_bit("tx parity", bits_q[1 + ds], parity_of(exp, frame_cfg));
        end
        check_bit("tx stop", bits_q[nbits - 1], 1'b1);
        if (frame_cfg.two_stop) begin
            check_bit("tx stop", bits_q[nbits - 2], 1'b1);
        end
        frames_seen++;
    endtask

    initial begin : line_decoder
        logic prev;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            // falling edge marks a start bit
            if (rst_n && prev && !tx) begin
                decode_frame();
            end
            prev = tx;
        end
    end

    always @(negedge clk) begin
        if (rst_n && tx_done) begin
            done_cnt++;
        end
    end

    task automatic await_grant(input logic [1:0] exp);
        int n;
        n = 0;
        while (grant == 2'b00) begin
            if (n == wait_limit) begin
                abort("timeout waiting for a grant");
            end
            step();
            n++;
        end
        check_grant("grant", grant, exp);
    endtask

    // owner still shown on the edge that samples req low, 00 one cycle later
    task automatic release_grant(input logic [1:0] owner);
        req = 2'b00;
        step();
        check_grant("grant", grant, owner);
        step();
        check_grant("grant", grant, 2'b00);
    endtask

    // other client writes garbage in the same cycle as the owner
    task automatic write_word(input int owner, input uart_tx_pkg::word_t d, input bit accept);
        client0.data = uart_tx_pkg::word_t'($urandom);
        client1.data = uart_tx_pkg::word_t'($urandom);
        client0.wr = 1'b1;
        client1.wr = 1'b1;
        if (owner == 0) begin
            client0.data = d;
        end else begin
            client1.data = d;
        end
        step();
        client0.wr = 1'b0;
        client1.wr = 1'b0;
        if (accept) begin
            expected_q.push_back(d);
            pushed_cnt++;
        end
    endtask

    task automatic await_frames();
        int n;
        n = 0;
        while (done_cnt != pushed_cnt) begin
            if (n == wait_limit) begin
                abort("timeout waiting for tx_done on the queued frames");
            end
            step();
            n++;
        end
        check_bit("tx_empty", tx_empty, 1'b1);
        check_level("tx_level", tx_level, '0);
        if (expected_q.size() != 0) begin
            errors++;
            $display("queued words never appeared on the line");
        end
    endtask

    // a lower prescaler can leave the counter above it until it wraps
    task automatic resync_baud();
        int n;
        n = 0;
        @(negedge clk);
        while (!i_dut.baud_tick) begin
            if (n == resync_limit) begin
                abort("timeout waiting for the baud tick");
            end
            @(negedge clk);
            n++;
        end
        step();
    endtask

    task automatic pick_format();
        prescaler = uart_tx_pkg::prescale_t'($urandom % 4);
        frame_cfg.data_size = uart_cfg_pkg::data_size_t'(5 + $urandom % 5);
        case ($urandom % 5)
            0:       frame_cfg.parity = uart_cfg_pkg::par_none;
            1:       frame_cfg.parity = uart_cfg_pkg::par_odd;
            2:       frame_cfg.parity = uart_cfg_pkg::par_even;
            3:       frame_cfg.parity = uart_cfg_pkg::par_sticky0;
            default: frame_cfg.parity = uart_cfg_pkg::par_sticky1;
        endcase
        frame_cfg.two_stop = 1'($urandom % 2);
        resync_baud();
    endtask

    // baud generator frozen mid-frame must hold the line
    task automatic stall_line();
        logic held;
        repeat (2 + $urandom % 24) step();
        en = 1'b0;
        step();
        held = tx;
        repeat (24) begin
            step();
            check_bit("tx", tx, held);
        end
        en = 1'b1;
    endtask

    task automatic run_batch(input int b);
        logic [1:0] exp;
        int owner;
        int nwords;
        pick_format();
        case (b % 3)
            0: begin
                req = 2'b11;
                exp = 2'b01;
            end
            1: begin
                req = 2'b10;
                exp = 2'b10;
            end
            default: begin
                req = 2'b01;
                exp = 2'b01;
            end
        endcase
        await_grant(exp);
        owner = (exp == 2'b01) ? 0 : 1;
        nwords = 1 + int'($urandom % 4);
        for (int i = 0; i < nwords; i++) begin
            write_word(owner, uart_tx_pkg::word_t'($urandom), 1'b1);
            if (b == 4 && i == 0) begin
                stall_line();
            end
        end
        release_grant(exp);
        await_frames();
    endtask

    // 17 writes with the transmitter held before the drain
    task automatic fill_and_drain();
        int base;
        tx_en = 1'b0;
        pick_format();
        req = 2'b01;
        await_grant(2'b01);
        for (int i = 1; i <= 17; i++) begin
            write_word(0, uart_tx_pkg::word_t'($urandom), i <= 16);
            check_level("tx_level", tx_level, uart_tx_pkg::level_t'(i <= 16 ? i : 16));
            check_bit("tx_full", tx_full, i >= 16);
        end
        release_grant(2'b01);
        base = done_cnt;
        tx_en = 1'b1;
        await_frames();
        if (done_cnt - base != 16) begin
            errors++;
            $display("expected 16 tx_done pulses after the fill, saw %0d", done_cnt - base);
        end
    endtask

    initial begin : stimulus
        void'($urandom(5188));
        rst_n = 1'b0;
        client0 = '0;
        client1 = '0;
        req = 2'b00;
        prescaler = '0;
        en = 1'b0;
        tx_en = 1'b0;
        frame_cfg.data_size = 4'd8;
        frame_cfg.parity = uart_cfg_pkg::par_none;
        frame_cfg.two_stop = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // reset values
        check_bit("tx_empty", tx_empty, 1'b1);
        check_bit("tx_full", tx_full, 1'b0);
        check_level("tx_level", tx_level, '0);
        check_grant("grant", grant, 2'b00);
        check_bit("tx", tx, 1'b1);
        en = 1'b1;
        tx_en = 1'b1;
        for (int b = 0; b < 12; b++) begin
            run_batch(b);
        end
        fill_and_drain();
        print_counts();
        if (errors == 0 && i_dut.i_assertions.fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/uart_tx_assertions.sv
// bound checks on grant ownership, FIFO flags, frame end and idle line
`timescale 1ns/1ps
`default_nettype none

module uart_tx_assertions (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic [1:0]          grant,
    input wire logic                tx_empty,
    input wire logic                tx_full,
    input wire uart_tx_pkg::level_t tx_level,
    input wire logic                tx_done,
    input wire logic                tx
);

    // failed assertions so far
    int fail_cnt = 0;

    // a new owner shows up only after the fifo was seen empty
    grant_on_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (grant != 2'b00 && $past(grant) == 2'b00) |-> $past(tx_empty, 2))
        else begin
            $error("grant given while the FIFO was not empty");
            fail_cnt++;
        end

    fifo_flags: assert property (@(posedge clk) disable iff (!rst_n) !(tx_full && tx_empty))
        else begin
            $error("tx_full and tx_empty both high");
            fail_cnt++;
        end

    // level wraps to 0 only when full
    empty_level: assert property (@(posedge clk) disable iff (!rst_n)
        tx_empty |-> (tx_level == '0))
        else begin
            $error("tx_level nonzero while empty");
            fail_cnt++;
        end

    // frame end releases a head that exists
    done_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |-> !tx_empty)
        else begin
            $error("tx_done while the FIFO is empty");
            fail_cnt++;
        end

    // the word on the line stays queued until its frame ends
    idle_line: assert property (@(posedge clk) disable iff (!rst_n)
        tx_empty |-> tx)
        else begin
            $error("tx low while the FIFO is empty");
            fail_cnt++;
        end

endmodule

// every check sees only top level ports
bind uart_tx_top uart_tx_assertions i_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .grant    (grant),
    .tx_empty (tx_empty),
    .tx_full  (tx_full),
    .tx_level (tx_level),
    .tx_done  (tx_done),
    .tx       (tx)
);

`default_nettype wire

// File: list.f
rtl/uart_cfg_pkg.sv
rtl/uart_tx_pkg.sv
rtl/tx_client_arbiter.sv
rtl/tx_fifo.sv
rtl/baud_gen.sv
rtl/tx_frame_ctrl.sv
rtl/tx_shifter.sv
rtl/uart_tx_top.sv
bench/uart_tx_assertions.sv
bench/tb_uart_tx.sv

// File: rtl/baud_gen.sv
// prescaler counter producing a one-cycle baud tick
`timescale 1ns/1ps
`default_nettype none

module baud_gen (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire uart_tx_pkg::prescale_t prescaler,
    input  wire logic                   en,
    output logic                        baud_tick
);

    uart_tx_pkg::prescale_t cnt;
    logic                   wrap;

    assign wrap = (cnt == prescaler);

    // counter frozen while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (en) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
        end
    end

    // no ticks while disabled
    assign baud_tick = en & wrap;

endmodule

`default_nettype wire

// File: rtl/tx_client_arbiter.sv
// two-client grant FSM with write mux into the TX FIFO
`timescale 1ns/1ps
`default_nettype none

module tx_client_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [1:0]             req,
    input  wire logic                   fifo_empty,
    input  wire uart_tx_pkg::client_wr_t client0,
    input  wire uart_tx_pkg::client_wr_t client1,
    output logic [1:0]                  grant,
    output uart_tx_pkg::client_wr_t     fifo_wr
);

    typedef enum logic [1:0] {
        arb_idle,
        arb_client0,
        arb_client1
    } arb_state_e;

    arb_state_e state, state_n;

    // only the current owner reaches the fifo
    always_comb begin
        case (grant)
            2'b01:   fifo_wr = client0;
            2'b10:   fifo_wr = client1;
            default: fifo_wr = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= arb_idle;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            arb_idle: begin
                // new owner only once the fifo has drained
                if (fifo_empty) begin
                    if (req[0]) begin
                        state_n = arb_client0;
                    end else if (req == 2'b10) begin
                        state_n = arb_client1;
                    end
                end
            end
            // hold until the owner lets go
            arb_client0: if (!req[0]) state_n = arb_idle;
            arb_client1: if (!req[1]) state_n = arb_idle;
            default:     state_n = arb_idle;
        endcase
    end

    // grant follows the state one clock later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= 2'b00;
        end else begin
            case (state)
                arb_client0: grant <= 2'b01;
                arb_client1: grant <= 2'b10;
                default:     grant <= 2'b00;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/tx_fifo.sv
// 16-word FIFO with registered level, full and empty flags
`timescale 1ns/1ps
`default_nettype none

module tx_fifo (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire uart_tx_pkg::client_wr_t wr_in,
    input  wire logic                    pop,
    output uart_tx_pkg::word_t           head,
    output logic                         empty,
    output logic                         full,
    output uart_tx_pkg::level_t          level
);

    uart_tx_pkg::word_t mem [uart_tx_pkg::fifo_depth];

    logic [uart_tx_pkg::fifo_aw-1:0] wr_ptr, wr_ptr_n, wr_succ;
    logic [uart_tx_pkg::fifo_aw-1:0] rd_ptr, rd_ptr_n, rd_succ;
    uart_tx_pkg::level_t             level_n;
    logic                            full_n, empty_n;
    logic                            wr_en, rd_en;

    // drop writes when full, ignore pops when empty
    assign wr_en = wr_in.wr & ~full;
    assign rd_en = pop & ~empty;

    assign wr_succ = wr_ptr + 1'b1;
    assign rd_succ = rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_in.data;
        end
    end

    // word at the read pointer
    assign head = mem[rd_ptr];

    always_comb begin
        wr_ptr_n = wr_ptr;
        rd_ptr_n = rd_ptr;
        level_n  = level;
        full_n   = full;
        empty_n  = empty;
        case ({wr_en, rd_en})
            2'b10: begin
                wr_ptr_n = wr_succ;
                level_n  = level + 1'b1;
                empty_n  = 1'b0;
                full_n   = (wr_succ == rd_ptr);
            end
            2'b01: begin
                rd_ptr_n = rd_succ;
                level_n  = level - 1'b1;
                full_n   = 1'b0;
                empty_n  = (rd_succ == wr_ptr);
            end
            // both pointers move with occupancy unchanged
            2'b11: begin
                wr_ptr_n = wr_succ;
                rd_ptr_n = rd_succ;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            wr_ptr <= wr_ptr_n;
            rd_ptr <= rd_ptr_n;
            level  <= level_n;
            full   <= full_n;
            empty  <= empty_n;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tx_frame_ctrl.sv
// frame FSM with sample and bit counters issuing load, shift and pop
`timescale 1ns/1ps
`default_nettype none

module tx_frame_ctrl (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     baud_tick,
    input  wire logic                     tx_en,
    input  wire uart_cfg_pkg::frame_cfg_t cfg,
    input  wire logic                     fifo_empty,
    output logic                          load,
    output logic                          shift,
    output logic                          pop,
    output logic                          tx_done,
    output uart_tx_pkg::bit_sel_e         bit_sel
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop0,
        st_stop1
    } frame_state_e;

    frame_state_e              state, state_n;
    uart_tx_pkg::sample_cnt_t  sample_cnt, sample_cnt_n;
    uart_cfg_pkg::data_size_t  bit_cnt, bit_cnt_n;
    uart_cfg_pkg::data_size_t  last_bit;
    logic                      tick;
    logic                      bit_end;

    // transmit side ticks only
    assign tick     = baud_tick & tx_en;
    assign bit_end  = tick && (sample_cnt == uart_tx_pkg::sample_last);
    assign last_bit = uart_cfg_pkg::clamp_size(cfg.data_size) - 4'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            state      <= state_n;
            sample_cnt <= sample_cnt_n;
            bit_cnt    <= bit_cnt_n;
        end
    end

    always_comb begin
        state_n      = state;
        sample_cnt_n = sample_cnt;
        bit_cnt_n    = bit_cnt;
        load         = 1'b0;
        shift        = 1'b0;
        pop          = 1'b0;
        tx_done      = 1'b0;
        // every bit period is sample_last+1 ticks
        if (state != st_idle && tick) begin
            sample_cnt_n = bit_end ? '0 : sample_cnt + 1'b1;
        end
        case (state)
            st_idle: begin
                if (!fifo_empty) begin
                    load         = 1'b1;
                    sample_cnt_n = '0;
                    state_n      = st_start;
                end
            end
            st_start: begin
                if (bit_end) begin
                    bit_cnt_n = '0;
                    state_n   = st_data;
                end
            end
            st_data: begin
                if (bit_end) begin
                    shift = 1'b1;
                    if (bit_cnt != last_bit) begin
                        bit_cnt_n = bit_cnt + 1'b1;
                    end else if (cfg.parity == uart_cfg_pkg::par_none) begin
                        state_n = st_stop0;
                    end else begin
                        state_n = st_parity;
                    end
                end
            end
            st_parity: if (bit_end) state_n = st_stop0;
            st_stop0: begin
                if (bit_end) begin
                    if (cfg.two_stop) begin
                        state_n = st_stop1;
                    end else begin
                        // frame done so the fifo head is released
                        tx_done = 1'b1;
                        pop     = 1'b1;
                        state_n = st_idle;
                    end
                end
            end
            st_stop1: begin
                if (bit_end) begin
                    tx_done = 1'b1;
                    pop     = 1'b1;
                    state_n = st_idle;
                end
            end
            default: state_n = st_idle;
        endcase
    end

    // line select for the shifter
    always_comb begin
        case (state)
            st_start:  bit_sel = uart_tx_pkg::sel_start;
            st_data:   bit_sel = uart_tx_pkg::sel_data;
            st_parity: bit_sel = uart_tx_pkg::sel_parity;
            st_stop0,
            st_stop1:  bit_sel = uart_tx_pkg::sel_stop;
            default:   bit_sel = uart_tx_pkg::sel_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/tx_shifter.sv
// data shift register, parity generation and registered serial line
`timescale 1ns/1ps
`default_nettype none

module tx_shifter (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire uart_cfg_pkg::frame_cfg_t cfg,
    input  wire uart_tx_pkg::word_t       head,
    input  wire logic                     load,
    input  wire logic                     shift,
    input  wire uart_tx_pkg::bit_sel_e    bit_sel,
    output logic                          tx
);

    uart_tx_pkg::word_t shreg;
    uart_tx_pkg::word_t masked;
    logic               par_bit;
    logic               par_q;

    // bits above data_size do not count toward parity
    assign masked = head & ~({uart_tx_pkg::word_w{1'b1}}
                             << uart_cfg_pkg::clamp_size(cfg.data_size));

    always_comb begin
        case (cfg.parity)
            uart_cfg_pkg::par_odd:     par_bit = ~^masked;
            uart_cfg_pkg::par_even:    par_bit = ^masked;
            uart_cfg_pkg::par_sticky1: par_bit = 1'b1;
            default:                   par_bit = 1'b0;
        endcase
    end

    // word and parity held for the whole frame
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= head;
            par_q <= par_bit;
        end else if (shift) begin
            // lsb first
            shreg <= shreg >> 1;
        end
    end

    // line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx <= 1'b1;
        end else begin
            case (bit_sel)
                uart_tx_pkg::sel_start:  tx <= 1'b0;
                uart_tx_pkg::sel_data:   tx <= shreg[0];
                uart_tx_pkg::sel_parity: tx <= par_q;
                default:                 tx <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_cfg_pkg.sv
// parity encoding, data size limits, frame config struct and size clamp
`default_nettype none

package uart_cfg_pkg;

    // parity mode as seen on the config bus
    typedef enum logic [2:0] {
        par_none    = 3'b000,
        par_odd     = 3'b001,
        par_even    = 3'b010,
        par_sticky0 = 3'b100,
        par_sticky1 = 3'b101
    } parity_e;

    // data bits per frame
    typedef logic [3:0] data_size_t;

    localparam data_size_t data_size_min = 4'd5;
    localparam data_size_t data_size_max = 4'd9;

    typedef struct packed {
        data_size_t data_size;
        parity_e    parity;
        // 0 one stop bit, 1 two
        logic       two_stop;
    } frame_cfg_t;

    // out of range sizes fall back to the nearest legal one
    function automatic data_size_t clamp_size(data_size_t size);
        if (size < data_size_min) begin
            return data_size_min;
        end
        if (size > data_size_max) begin
            return data_size_max;
        end
        return size;
    endfunction

endpackage

`default_nettype wire

// File: rtl/uart_tx_pkg.sv
// word width, FIFO size, sample count, client write struct and line select enum
`default_nettype none

package uart_tx_pkg;

    // widest frame sets the word
    localparam int word_w = uart_cfg_pkg::data_size_max;
    localparam int fifo_aw = 4;
    localparam int fifo_depth = 2 ** fifo_aw;

    // baud ticks per bit on the line
    localparam int samples_per_bit = 8;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [fifo_aw-1:0] level_t;
    typedef logic [15:0]        prescale_t;
    typedef logic [$clog2(samples_per_bit)-1:0] sample_cnt_t;

    // last sample of a bit period
    localparam sample_cnt_t sample_last = sample_cnt_t'(samples_per_bit - 1);

    typedef struct packed {
        word_t data;
        logic  wr;
    } client_wr_t;

    // what the line carries next
    typedef enum logic [2:0] {
        sel_idle,
        sel_start,
        sel_data,
        sel_parity,
        sel_stop
    } bit_sel_e;

endpackage

`default_nettype wire

// File: rtl/uart_tx_top.sv
// top level wiring arbiter, TX FIFO, baud generator, frame controller and shifter
`timescale 1ns/1ps
`default_nettype none

module uart_tx_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire uart_tx_pkg::client_wr_t  client0,
    input  wire uart_tx_pkg::client_wr_t  client1,
    input  wire logic [1:0]               req,
    input  wire uart_tx_pkg::prescale_t   prescaler,
    input  wire logic                     en,
    input  wire logic                     tx_en,
    input  wire uart_cfg_pkg::frame_cfg_t frame_cfg,
    output logic [1:0]                    grant,
    output logic                          tx_empty,
    output logic                          tx_full,
    output uart_tx_pkg::level_t           tx_level,
    output logic                          tx_done,
    output logic                          tx
);

    uart_tx_pkg::client_wr_t fifo_wr;
    uart_tx_pkg::word_t      head;
    uart_tx_pkg::bit_sel_e   bit_sel;
    logic                    baud_tick;
    logic                    load;
    logic                    shift;
    logic                    pop;

    // write side
    tx_client_arbiter i_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .fifo_empty (tx_empty),
        .client0    (client0),
        .client1    (client1),
        .grant      (grant),
        .fifo_wr    (fifo_wr)
    );

    tx_fifo i_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_in (fifo_wr),
        .pop   (pop),
        .head  (head),
        .empty (tx_empty),
        .full  (tx_full),
        .level (tx_level)
    );

    // bit timing
    baud_gen i_baud_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .prescaler (prescaler),
        .en        (en),
        .baud_tick (baud_tick)
    );

    // serializer
    tx_frame_ctrl i_frame_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_tick  (baud_tick),
        .tx_en      (tx_en),
        .cfg        (frame_cfg),
        .fifo_empty (tx_empty),
        .load       (load),
        .shift      (shift),
        .pop        (pop),
        .tx_done    (tx_done),
        .bit_sel    (bit_sel)
    );

    tx_shifter i_shifter (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (frame_cfg),
        .head    (head),
        .load    (load),
        .shift   (shift),
        .bit_sel (bit_sel),
        .tx      (tx)
    );

endmodule

`default_nettype wire
